//--- hdl/serial_bus_pkg.sv
`default_nettype none

package serial_bus_pkg;

	localparam int PORT_SEL_W = 3; // Up to 8 ports

	typedef logic [7:0] reg_data_t;
	typedef logic [2:0] reg_offset_t;
	typedef logic [PORT_SEL_W-1:0] port_sel_t;

	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [3:0] axi_strb_t;
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

	typedef struct packed {
		axi_addr_t addr;
	} axi_aw_t;

	typedef struct packed {
		axi_data_t data;
		axi_strb_t strb;
	} axi_w_t;

	typedef struct packed {
		axi_data_t data;
		axi_resp_t resp;
	} axi_r_t;

	// Byte-wide register bus, strobes last one cycle
	typedef struct packed {
		port_sel_t port;
		reg_offset_t offset;
		reg_data_t wdata;
		logic wr;
		logic rd;
	} reg_req_t;

endpackage

`default_nettype wire

//--- hdl/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// Register offsets inside one port, offset 6 is unused
	localparam logic [2:0] REG_DATA = 3'd0;
	localparam logic [2:0] REG_IER = 3'd1;
	localparam logic [2:0] REG_LSR = 3'd2;
	localparam logic [2:0] REG_DIV = 3'd3;
	localparam logic [2:0] REG_MCR = 3'd4;
	localparam logic [2:0] REG_MSR = 3'd5;
	localparam logic [2:0] REG_SCR = 3'd7;

	localparam int LSR_DR = 0;   // Receive data ready
	localparam int LSR_OE = 1;   // Overrun
	localparam int LSR_TEMT = 5; // Transmitter empty

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	typedef struct packed {
		logic cts;
		logic dsr;
		logic ri;
		logic dcd;
	} modem_in_t;

endpackage

`default_nettype wire

//--- hdl/axi_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_reg_bridge
	import serial_bus_pkg::*;
#(
	parameter int PORT_NUM = 4
)
(
	input wire aclk_i,
	input wire rst_n_i,

	input wire axi_aw_t aw_i,
	input wire awvalid_i,
	output logic awready_o,

	input wire axi_w_t w_i,
	input wire wvalid_i,
	output logic wready_o,

	output axi_resp_t bresp_o,
	output logic bvalid_o,
	input wire bready_i,

	input wire axi_addr_t araddr_i,
	input wire arvalid_i,
	output logic arready_o,

	output axi_r_t r_o,
	output logic rvalid_o,
	input wire rready_i,

	output reg_req_t reg_req_o,
	input wire reg_data_t rd_data_i
);

	typedef enum logic [1:0] {
		W_IDLE,
		W_STRB,
		W_RESP
	} wr_state_e;

	typedef enum logic [1:0] {
		R_IDLE,
		R_STRB,
		R_RESP
	} rd_state_e;

	wr_state_e wr_state_q;
	rd_state_e rd_state_q;
	logic prio_wr_q; // Write wins the next collision

	port_sel_t port_q;
	reg_offset_t offset_q;
	reg_data_t wdata_q;
	logic wen_q;
	logic ren_q;
	reg_data_t rdata_q;

	port_sel_t aw_port;
	port_sel_t ar_port;
	logic wr_ok;
	logic rd_ok;
	logic wr_req;
	logic rd_req;
	logic wr_turn;
	logic rd_turn;
	logic wr_grant;
	logic rd_grant;

	assign aw_port = aw_i.addr[5 +: PORT_SEL_W];
	assign ar_port = araddr_i[5 +: PORT_SEL_W];

	assign wr_ok = wr_state_q == W_IDLE;
	assign rd_ok = rd_state_q == R_IDLE;
	assign wr_req = awvalid_i & wvalid_i & wr_ok;
	assign rd_req = arvalid_i & rd_ok;
	assign wr_turn = prio_wr_q | !rd_req;
	assign rd_turn = !prio_wr_q | !wr_req;
	assign wr_grant = wr_req & wr_turn;
	assign rd_grant = rd_req & rd_turn;

	// aw and w are only taken together
	assign awready_o = wr_ok & wr_turn & (wvalid_i | !awvalid_i);
	assign wready_o = wr_ok & wr_turn & (awvalid_i | !wvalid_i);
	assign arready_o = rd_ok & rd_turn;

	always_ff @(posedge aclk_i)
	begin
		if (!rst_n_i)
		begin
			wr_state_q <= W_IDLE;
			rd_state_q <= R_IDLE;
			prio_wr_q <= 1'b1;
		end
		else
		begin
			case (wr_state_q)
				W_IDLE: if (wr_grant) wr_state_q <= W_STRB;
				W_STRB: wr_state_q <= bready_i ? W_IDLE : W_RESP;
				W_RESP: if (bready_i) wr_state_q <= W_IDLE;
				default: wr_state_q <= W_IDLE;
			endcase
			case (rd_state_q)
				R_IDLE: if (rd_grant) rd_state_q <= R_STRB;
				R_STRB: rd_state_q <= R_RESP;
				R_RESP: if (rready_i) rd_state_q <= R_IDLE;
				default: rd_state_q <= R_IDLE;
			endcase
			if (wr_grant)
				prio_wr_q <= 1'b0;
			else if (rd_grant)
				prio_wr_q <= 1'b1;
		end
	end

	// Request fields, only one grant per edge
	always_ff @(posedge aclk_i)
	begin
		if (wr_grant)
		begin
			port_q <= aw_port;
			offset_q <= aw_i.addr[4:2];
			wdata_q <= w_i.data[7:0];
			wen_q <= w_i.strb[0] & (int'(aw_port) < PORT_NUM);
		end
		else if (rd_grant)
		begin
			port_q <= ar_port;
			offset_q <= araddr_i[4:2];
			ren_q <= int'(ar_port) < PORT_NUM;
		end
		if (rd_state_q == R_STRB)
			rdata_q <= ren_q ? rd_data_i : '0; // Missing ports read as zero
	end

	always_comb
	begin
		reg_req_o.port = port_q;
		reg_req_o.offset = offset_q;
		reg_req_o.wdata = wdata_q;
		reg_req_o.wr = (wr_state_q == W_STRB) & wen_q;
		reg_req_o.rd = (rd_state_q == R_STRB) & ren_q;
	end

	assign bvalid_o = wr_state_q != W_IDLE;
	assign bresp_o = AXI_RESP_OKAY;
	assign rvalid_o = rd_state_q == R_RESP;
	assign r_o = '{data: {24'b0, rdata_q}, resp: AXI_RESP_OKAY};

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
	import serial_bus_pkg::*;
	import uart_pkg::*;
#(
	parameter int CLOCK_PRESCALE = 1
)
(
	input wire aclk_i,
	input wire rst_n_i,
	input wire load_i,
	input wire reg_data_t data_i,
	input wire reg_data_t divisor_i,
	output logic txd_o,
	output logic busy_o
);

	localparam int CNT_W = $clog2(256 * CLOCK_PRESCALE + 1);

	tx_state_e state_q;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] bit_len;
	logic [2:0] bit_idx_q;
	reg_data_t shift_q;

	assign bit_len = CNT_W'((int'(divisor_i) + 1) * CLOCK_PRESCALE);

	always_ff @(posedge aclk_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= TX_IDLE;
			txd_o <= 1'b1;
			cnt_q <= '0;
			bit_idx_q <= '0;
		end
		else if (state_q == TX_IDLE)
		begin
			if (load_i)
			begin
				shift_q <= data_i;
				txd_o <= 1'b0; // Start bit
				cnt_q <= bit_len - 1'b1;
				state_q <= TX_START;
			end
		end
		else if (cnt_q != '0)
			cnt_q <= cnt_q - 1'b1;
		else
		begin
			cnt_q <= bit_len - 1'b1;
			case (state_q)
				TX_START:
				begin
					txd_o <= shift_q[0];
					shift_q <= shift_q >> 1;
					bit_idx_q <= '0;
					state_q <= TX_DATA;
				end
				TX_DATA:
				begin
					if (bit_idx_q == 3'd7)
					begin
						txd_o <= 1'b1; // Stop bit
						state_q <= TX_STOP;
					end
					else
					begin
						txd_o <= shift_q[0]; // LSB first
						shift_q <= shift_q >> 1;
						bit_idx_q <= bit_idx_q + 1'b1;
					end
				end
				default: state_q <= TX_IDLE;
			endcase
		end
	end

	assign busy_o = state_q != TX_IDLE;

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
	import serial_bus_pkg::*;
	import uart_pkg::*;
#(
	parameter int CLOCK_PRESCALE = 1
)
(
	input wire aclk_i,
	input wire rst_n_i,
	input wire rxd_i,
	input wire reg_data_t divisor_i,
	output logic valid_o,
	output reg_data_t data_o
);

	localparam int CNT_W = $clog2(256 * CLOCK_PRESCALE + 1);

	rx_state_e state_q;
	logic rxd_meta_q;
	logic rxd_sync_q;
	logic rxd_prev_q;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] bit_len;
	logic [2:0] bit_idx_q;
	reg_data_t shift_q;

	assign bit_len = CNT_W'((int'(divisor_i) + 1) * CLOCK_PRESCALE);

	always_ff @(posedge aclk_i)
	begin
		if (!rst_n_i)
		begin
			rxd_meta_q <= 1'b1;
			rxd_sync_q <= 1'b1;
			rxd_prev_q <= 1'b1;
			state_q <= RX_IDLE;
			cnt_q <= '0;
			bit_idx_q <= '0;
			valid_o <= 1'b0;
		end
		else
		begin
			rxd_meta_q <= rxd_i;
			rxd_sync_q <= rxd_meta_q;
			rxd_prev_q <= rxd_sync_q;
			valid_o <= 1'b0;
			if (state_q == RX_IDLE)
			begin
				if (rxd_prev_q && !rxd_sync_q)
				begin
					cnt_q <= (bit_len - 1'b1) >> 1; // Mid-bit, edge detect already took a cycle
					state_q <= RX_START;
				end
			end
			else if (cnt_q != '0)
				cnt_q <= cnt_q - 1'b1;
			else
			begin
				cnt_q <= bit_len - 1'b1;
				case (state_q)
					RX_START:
					begin
						bit_idx_q <= '0;
						state_q <= rxd_sync_q ? RX_IDLE : RX_DATA; // Glitch, not a start bit
					end
					RX_DATA:
					begin
						shift_q <= {rxd_sync_q, shift_q[7:1]};
						bit_idx_q <= bit_idx_q + 1'b1;
						if (bit_idx_q == 3'd7)
							state_q <= RX_STOP;
					end
					default:
					begin
						valid_o <= rxd_sync_q; // Framing error drops the byte
						state_q <= RX_IDLE;
					end
				endcase
			end
		end
	end

	assign data_o = shift_q;

endmodule

`default_nettype wire

//--- hdl/uart_port_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_port_regs
	import serial_bus_pkg::*;
	import uart_pkg::*;
#(
	parameter int PORT_INDEX = 0,
	parameter int CLOCK_PRESCALE = 1
)
(
	input wire aclk_i,
	input wire rst_n_i,
	input wire reg_req_t reg_req_i,
	output reg_data_t rd_data_o,
	input wire modem_in_t modem_i,
	input wire rxd_i,
	output logic txd_o,
	output logic rts_o,
	output logic dtr_o,
	output logic irq_o
);

	reg_data_t ier_q;
	reg_data_t div_q;
	reg_data_t mcr_q;
	reg_data_t scr_q;
	reg_data_t rbr_q;
	reg_data_t lsr;
	reg_data_t rx_data;
	logic dr_q;
	logic oe_q;
	logic temt;
	logic tx_busy;
	logic tx_load;
	logic rx_valid;
	logic wr_en;
	logic rd_en;

	assign wr_en = reg_req_i.wr & (reg_req_i.port == port_sel_t'(PORT_INDEX));
	assign rd_en = reg_req_i.rd & (reg_req_i.port == port_sel_t'(PORT_INDEX));

	assign temt = !tx_busy;
	assign tx_load = wr_en & (reg_req_i.offset == REG_DATA) & temt; // Dropped while sending

	always_ff @(posedge aclk_i)
	begin
		if (!rst_n_i)
		begin
			ier_q <= '0;
			div_q <= 8'd1;
			mcr_q <= '0;
			scr_q <= '0;
		end
		else if (wr_en)
		begin
			case (reg_req_i.offset)
				REG_IER: ier_q <= reg_req_i.wdata;
				REG_DIV: div_q <= reg_req_i.wdata;
				REG_MCR: mcr_q <= reg_req_i.wdata;
				REG_SCR: scr_q <= reg_req_i.wdata;
				default: ;
			endcase
		end
	end

	always_ff @(posedge aclk_i)
	begin
		if (rx_valid)
			rbr_q <= rx_data;
	end

	// A new byte beats the clear from a DATA read
	always_ff @(posedge aclk_i)
	begin
		if (!rst_n_i)
		begin
			dr_q <= 1'b0;
			oe_q <= 1'b0;
		end
		else
		begin
			if (rd_en && reg_req_i.offset == REG_LSR)
				oe_q <= 1'b0;
			if (rx_valid)
			begin
				dr_q <= 1'b1;
				if (dr_q)
					oe_q <= 1'b1;
			end
			else if (rd_en && reg_req_i.offset == REG_DATA)
				dr_q <= 1'b0;
		end
	end

	always_comb
	begin
		lsr = '0;
		lsr[LSR_DR] = dr_q;
		lsr[LSR_OE] = oe_q;
		lsr[LSR_TEMT] = temt;
	end

	always_comb
	begin
		case (reg_req_i.offset)
			REG_DATA: rd_data_o = rbr_q;
			REG_IER: rd_data_o = ier_q;
			REG_LSR: rd_data_o = lsr;
			REG_DIV: rd_data_o = div_q;
			REG_MCR: rd_data_o = mcr_q;
			REG_MSR: rd_data_o = {4'b0, modem_i.cts, modem_i.dsr, modem_i.ri, modem_i.dcd};
			REG_SCR: rd_data_o = scr_q;
			default: rd_data_o = '0;
		endcase
	end

	assign rts_o = !mcr_q[1]; // Active low lines
	assign dtr_o = !mcr_q[0];
	assign irq_o = (dr_q & ier_q[0]) | (temt & ier_q[1]);

	uart_tx #(.CLOCK_PRESCALE(CLOCK_PRESCALE)) u_tx (
		.aclk_i(aclk_i),
		.rst_n_i(rst_n_i),
		.load_i(tx_load),
		.data_i(reg_req_i.wdata),
		.divisor_i(div_q),
		.txd_o(txd_o),
		.busy_o(tx_busy)
	);

	uart_rx #(.CLOCK_PRESCALE(CLOCK_PRESCALE)) u_rx (
		.aclk_i(aclk_i),
		.rst_n_i(rst_n_i),
		.rxd_i(rxd_i),
		.divisor_i(div_q),
		.valid_o(rx_valid),
		.data_o(rx_data)
	);

endmodule

`default_nettype wire

//--- hdl/multi_serial.sv
`timescale 1ns/1ps
`default_nettype none

module multi_serial
	import serial_bus_pkg::*;
	import uart_pkg::*;
#(
	parameter int PORT_NUM = 4,
	parameter int CLOCK_PRESCALE = 1
)
(
	input wire aclk_i,
	input wire rst_n_i,

	input wire axi_aw_t aw_i,
	input wire awvalid_i,
	output logic awready_o,

	input wire axi_w_t w_i,
	input wire wvalid_i,
	output logic wready_o,

	output axi_resp_t bresp_o,
	output logic bvalid_o,
	input wire bready_i,

	input wire axi_addr_t araddr_i,
	input wire arvalid_i,
	output logic arready_o,

	output axi_r_t r_o,
	output logic rvalid_o,
	input wire rready_i,

	input wire [PORT_NUM-1:0] rxd_i,
	output logic [PORT_NUM-1:0] txd_o,
	output logic [PORT_NUM-1:0] rts_o,
	output logic [PORT_NUM-1:0] dtr_o,
	input wire [PORT_NUM-1:0] cts_i,
	input wire [PORT_NUM-1:0] dsr_i,
	input wire [PORT_NUM-1:0] ri_i,
	input wire [PORT_NUM-1:0] dcd_i,

	output logic interrupt_o
);

	reg_req_t reg_req;
	reg_data_t rd_data;
	reg_data_t port_rd_data [PORT_NUM];
	logic [PORT_NUM-1:0] port_irq;

	// Ports outside the array read as zero
	always_comb
	begin
		rd_data = '0;
		for (int i = 0; i < PORT_NUM; i++)
		begin
			if (int'(reg_req.port) == i)
				rd_data = port_rd_data[i];
		end
	end

	assign interrupt_o = |port_irq;

	axi_reg_bridge #(.PORT_NUM(PORT_NUM)) u_bridge (
		.aclk_i(aclk_i),
		.rst_n_i(rst_n_i),
		.aw_i(aw_i),
		.awvalid_i(awvalid_i),
		.awready_o(awready_o),
		.w_i(w_i),
		.wvalid_i(wvalid_i),
		.wready_o(wready_o),
		.bresp_o(bresp_o),
		.bvalid_o(bvalid_o),
		.bready_i(bready_i),
		.araddr_i(araddr_i),
		.arvalid_i(arvalid_i),
		.arready_o(arready_o),
		.r_o(r_o),
		.rvalid_o(rvalid_o),
		.rready_i(rready_i),
		.reg_req_o(reg_req),
		.rd_data_i(rd_data)
	);

	for (genvar i = 0; i < PORT_NUM; i++)
	begin : g_port
		modem_in_t modem;

		assign modem = '{cts: cts_i[i], dsr: dsr_i[i], ri: ri_i[i], dcd: dcd_i[i]};

		uart_port_regs #(
			.PORT_INDEX(i),
			.CLOCK_PRESCALE(CLOCK_PRESCALE)
		) u_port (
			.aclk_i(aclk_i),
			.rst_n_i(rst_n_i),
			.reg_req_i(reg_req),
			.rd_data_o(port_rd_data[i]),
			.modem_i(modem),
			.rxd_i(rxd_i[i]),
			.txd_o(txd_o[i]),
			.rts_o(rts_o[i]),
			.dtr_o(dtr_o[i]),
			.irq_o(port_irq[i])
		);
	end

endmodule

`default_nettype wire

//--- verification/multi_serial_tb.sv
`timescale 1ns/1ps
`default_nettype none

module multi_serial_tb
	import serial_bus_pkg::*;
();

	localparam int PORT_NUM = 4;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_OP = 2000;
	localparam int POLL_LIMIT = 200; // Reads before a poll gives up
	localparam string TRACE_FILE = "verification/multi_serial_trace.txt";

	logic clk;
	logic rst_n;
	axi_aw_t aw;
	logic awvalid;
	logic awready;
	axi_w_t w;
	logic wvalid;
	logic wready;
	axi_resp_t bresp;
	logic bvalid;
	logic bready;
	axi_addr_t araddr;
	logic arvalid;
	logic arready;
	axi_r_t r;
	logic rvalid;
	logic rready;
	logic [PORT_NUM-1:0] txd;
	logic [PORT_NUM-1:0] rxd;
	logic [PORT_NUM-1:0] rts;
	logic [PORT_NUM-1:0] dtr;
	logic [PORT_NUM-1:0] cts;
	logic [PORT_NUM-1:0] dsr;
	logic [PORT_NUM-1:0] ri;
	logic [PORT_NUM-1:0] dcd;
	logic irq;
	logic [15:0] modem_q; // One nibble {cts, dsr, ri, dcd} per port

	int seed = 32'h7bf7a312;
	int cycle_cnt = 0;
	int cycle_limit = 0;

	assign rxd = {txd[2:0], txd[3]}; // Port k feeds port k+1

	always_comb
	begin
		for (int k = 0; k < PORT_NUM; k++)
		begin
			cts[k] = modem_q[4*k+3];
			dsr[k] = modem_q[4*k+2];
			ri[k] = modem_q[4*k+1];
			dcd[k] = modem_q[4*k];
		end
	end

	multi_serial #(
		.PORT_NUM(PORT_NUM),
		.CLOCK_PRESCALE(1)
	) uut (
		.aclk_i(clk),
		.rst_n_i(rst_n),
		.aw_i(aw),
		.awvalid_i(awvalid),
		.awready_o(awready),
		.w_i(w),
		.wvalid_i(wvalid),
		.wready_o(wready),
		.bresp_o(bresp),
		.bvalid_o(bvalid),
		.bready_i(bready),
		.araddr_i(araddr),
		.arvalid_i(arvalid),
		.arready_o(arready),
		.r_o(r),
		.rvalid_o(rvalid),
		.rready_i(rready),
		.rxd_i(rxd),
		.txd_o(txd),
		.rts_o(rts),
		.dtr_o(dtr),
		.cts_i(cts),
		.dsr_i(dsr),
		.ri_i(ri),
		.dcd_i(dcd),
		.interrupt_o(irq)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
		begin
			$display("Run timed out after %0d cycles", cycle_cnt);
			$display("Simulation FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t: %s got %h, expected %h", $time, what, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	// Back-pressure on the response channels
	task automatic random_wait();
		int n;
		n = $random(seed) & 3;
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic axi_write(input axi_addr_t addr, input logic [31:0] data,
		input logic [3:0] strb, input string what);
		aw = '{addr: addr};
		w = '{data: data, strb: strb};
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		while (!(awready && wready))
			@(negedge clk);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		random_wait();
		bready = 1'b1;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		check_value({30'b0, bresp}, {30'b0, AXI_RESP_OKAY}, what);
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, output logic [31:0] data,
		input string what);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		random_wait();
		rready = 1'b1;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		data = r.data;
		check_value({30'b0, r.resp}, {30'b0, AXI_RESP_OKAY}, what);
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic poll_until(input axi_addr_t addr, input logic [31:0] mask,
		input logic [31:0] expected, input string what);
		int reads;
		logic [31:0] data;
		logic hit;
		reads = 0;
		hit = 1'b0;
		while (!hit && reads < POLL_LIMIT)
		begin
			axi_read(addr, data, what);
			reads++;
			hit = (data & mask) == expected;
		end
		if (!hit)
		begin
			$display("Poll timed out: %s never reached %h after %0d reads", what, expected, reads);
			$display("Simulation FAILED");
			$fatal(1, "poll limit reached");
		end
	endtask

	function automatic logic is_op_line(input string line);
		return line.len() > 0 && line[0] >= "A" && line[0] <= "Z";
	endfunction

	task automatic open_trace(output int fd);
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0)
		begin
			$display("Could not open the trace file %s", TRACE_FILE);
			$display("Simulation FAILED");
			$fatal(1, "missing trace");
		end
	endtask

	task automatic count_ops(output int n);
		int fd;
		string line;
		n = 0;
		open_trace(fd);
		while ($fgets(line, fd) != 0)
		begin
			if (is_op_line(line))
				n++;
		end
		$fclose(fd);
	endtask

	task automatic run_trace();
		int fd;
		int line_no;
		int n;
		string line;
		string what;
		byte op;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] v3;
		logic [31:0] data;
		line_no = 0;
		open_trace(fd);
		while ($fgets(line, fd) != 0)
		begin
			line_no++;
			if (is_op_line(line))
			begin
				v1 = '0;
				v2 = '0;
				v3 = '0;
				n = $sscanf(line, "%c %h %h %h", op, v1, v2, v3);
				what = $sformatf("trace line %0d (%c %h)", line_no, op, v1);
				case (op)
					"W": axi_write(v1, v2, (n > 3) ? v3[3:0] : 4'hf, what);
					"R":
					begin
						axi_read(v1, data, what);
						check_value(data, v2, what);
					end
					"P": poll_until(v1, v2, v3, what);
					"M": modem_q = v1[15:0];
					"I": check_value({31'b0, irq}, v1, what);
					"O": check_value({24'b0, rts, dtr}, v1, what); // {rts, dtr} nibbles
					default:
					begin
						$display("Unknown operation on trace line %0d", line_no);
						$display("Simulation FAILED");
						$fatal(1, "bad trace");
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	initial
	begin
		int n_ops;
		rst_n = 1'b0;
		aw = '0;
		w = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		modem_q = '0;
		count_ops(n_ops);
		cycle_limit = n_ops * CYCLES_PER_OP + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_value({28'b0, txd}, 32'h0000000f, "txd idle after reset");
		// {awready, wready, arready, bvalid, rvalid}
		check_value({27'b0, awready, wready, arready, bvalid, rvalid}, 32'h0000001c,
			"AXI handshake outputs after reset");
		run_trace();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/multi_serial_trace.txt
# Columns: W addr data [strb] | R addr expected | P addr mask expected | M value | I expected | O expected
# Hex values; addr = port*20 + offset*4; M nibble per port {cts,dsr,ri,dcd}; O is {rts,dtr}
I 0
O ff
R 0c 01
R 08 20
R 68 20
R 24 00
W 1c a5
W 3c 5a
W 5c c3
W 7c 3c
R 1c a5
R 3c 5a
R 5c c3
R 7c 3c
W 3c ff e
R 3c 5a
W 0c 02
W 2c 03
W 4c 04
W 6c 05
R 0c 02
R 2c 03
R 4c 04
R 6c 05
W 0c 01
W 2c 01
W 4c 01
W 6c 01
W 00 6b
P 28 01 01
R 20 6b
R 28 20
W 20 11
P 28 20 20
W 20 22
P 48 02 02
R 48 21
R 40 22
R 48 20
W 24 01
I 0
W 00 9e
P 28 01 01
I 1
R 20 9e
I 0
W 24 00
W 64 02
I 1
W 64 00
I 0
M a005
R 14 05
R 34 00
R 74 0a
W 50 02
O bf
W 10 01
O be
R 10 01

//--- list.f
hdl/serial_bus_pkg.sv
hdl/uart_pkg.sv
hdl/axi_reg_bridge.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_port_regs.sv
hdl/multi_serial.sv
verification/multi_serial_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module multi_serial_tb \
	--Mdir obj_dir -o multi_serial_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/multi_serial_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
